//--- verilog.f
verilog/ddr_wr_pkg.sv
verilog/fwft_fifo.sv
verilog/ddr_wr_control.sv
verilog/ddr_wr_top.sv
verification/ddr_wr_checker.sv
verification/tb_ddr_wr.sv

//--- Makefile
VERILATOR := verilator
FLAGS     := --binary --timing --assert -Wno-fatal
TOP       := tb_ddr_wr
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verification/tb_ddr_wr.sv
module tb_ddr_wr
    import ddr_wr_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_TESTS = 6;
    localparam int WAIT_MAX = 4000;

    // stimulus table with one row per test
    // waveforms, bursts per waveform, fixed_start_en, fixed_start_addr,
    // header start address, ready duty in percent, bad first tag
    int tbl_nwfm [N_TESTS]  = '{1, 2, 3, 0, 4, 0};
    int tbl_burst [N_TESTS] = '{4, 3, 5, 0, 16, 0};
    bit tbl_fixed [N_TESTS] = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0};
    logic [ADDR_W-1:0] tbl_faddr [N_TESTS] = '{23'h0, 23'h0, 23'h012340, 23'h0, 23'h0, 23'h0};
    logic [ADDR_W-1:0] tbl_haddr [N_TESTS] =
        '{23'h000100, 23'h7ffff0, 23'h055555, 23'h000200, 23'h3a0000, 23'h0};
    int tbl_duty [N_TESTS]  = '{100, 70, 50, 100, 35, 100};
    bit tbl_bad [N_TESTS]   = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};

    logic clk;
    logic reset;
    logic acq_enabled;
    logic acq_done;
    logic adc_wr_en;
    acq_word_t adc_wr_dat;
    logic adc_fifo_full;
    logic app_wdf_wren;
    logic app_wdf_end;
    logic [127:0] app_wdf_data;
    logic app_wdf_rdy;
    logic app_en;
    logic [APP_ADDR_W-1:0] app_addr;
    logic app_rdy;
    logic [ADDR_W-1:0] fixed_start_addr;
    logic fixed_start_en;
    logic hdr_rd_en;
    hdr_record_t hdr_rd_dat;
    logic hdr_empty;
    logic sync_err;
    logic wr_done;

    logic [31:0] rnd_state;
    int duty;

    ddr_wr_top #(
        .DATA_FIFO_DEPTH (64),
        .HDR_FIFO_DEPTH  (8)
    ) i_dut (
        .clk (clk), .reset (reset), .acq_enabled (acq_enabled), .acq_done (acq_done),
        .adc_wr_en (adc_wr_en), .adc_wr_dat (adc_wr_dat), .adc_fifo_full (adc_fifo_full),
        .app_wdf_wren (app_wdf_wren), .app_wdf_end (app_wdf_end),
        .app_wdf_data (app_wdf_data), .app_wdf_rdy (app_wdf_rdy),
        .app_en (app_en), .app_addr (app_addr), .app_rdy (app_rdy),
        .fixed_start_addr (fixed_start_addr), .fixed_start_en (fixed_start_en),
        .hdr_rd_en (hdr_rd_en), .hdr_rd_dat (hdr_rd_dat), .hdr_empty (hdr_empty),
        .sync_err (sync_err), .wr_done (wr_done)
    );

    ddr_wr_checker i_chk (
        .clk (clk), .reset (reset),
        .app_wdf_wren (app_wdf_wren), .app_wdf_end (app_wdf_end),
        .app_wdf_rdy (app_wdf_rdy), .app_wdf_data (app_wdf_data),
        .app_en (app_en), .app_rdy (app_rdy),
        .app_addr (app_addr), .hdr_rd_en (hdr_rd_en), .hdr_rd_dat (hdr_rd_dat),
        .hdr_empty (hdr_empty)
    );

    // 32-bit LCG for the ready pattern
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // DDR3 app port model
    // each ready is drawn from the LCG at the row's duty
    always @(posedge clk) begin
        #2;
        rnd_state = lcg_next(rnd_state);
        app_wdf_rdy = (int'(rnd_state[30:16]) % 100) < duty;
        rnd_state = lcg_next(rnd_state);
        app_rdy = (int'(rnd_state[30:16]) % 100) < duty;
    end

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic abort_on_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("ERRORS FOUND");
        $finish;
    endtask

    task automatic wait_level(input string what, ref logic sig, input logic level);
        int n;
        n = 0;
        while (sig !== level) begin
            if (n == WAIT_MAX) abort_on_timeout(what);
            n++;
            step();
        end
    endtask

    // push one word and hold off while the data FIFO is full
    task automatic push_word(input logic [3:0] tag, input logic [127:0] p, input bit track);
        wait_level("data FIFO space", adc_fifo_full, 1'b0);
        adc_wr_en = 1'b1;
        adc_wr_dat.tag = tag;
        adc_wr_dat.payload = p;
        if (track) i_chk.expect_word(p);
        step();
        adc_wr_en = 1'b0;
    endtask

    task automatic run_fill(input int t);
        logic [127:0] p;
        logic [ADDR_W-1:0] start;
        p = {64'hfeed_0000_0000_0000 | 64'(t), 64'h0123_4567_89ab_cdef};
        p[START_ADDR_LSB +: ADDR_W] = tbl_haddr[t];
        start = tbl_fixed[t] ? tbl_faddr[t] : tbl_haddr[t];
        i_chk.start_test(t, start, p, tbl_nwfm[t], tbl_burst[t], tbl_bad[t]);
        if (tbl_bad[t]) begin
            push_word(4'd3, p, 1'b0);
            wait_level("sync_err high", sync_err, 1'b1);
            repeat (20) step();
            acq_enabled = 1'b0;
            wait_level("sync_err low", sync_err, 1'b0);
            // flush the stray word left in the data FIFO
            reset = 1'b1;
            repeat (2) step();
            reset = 1'b0;
            acq_enabled = 1'b1;
        end else begin
            push_word(TAG_FILL_HDR, p, 1'b1);
            for (int w = 0; w < tbl_nwfm[t]; w++) begin
                p = '0;
                p[127:96] = 32'hbeef_0000 + 32'(w);
                p[BURST_CNT_LSB +: BURST_CNT_W] = BURST_CNT_W'(tbl_burst[t]);
                push_word(TAG_WFM_HDR, p, 1'b1);
                for (int b = 0; b < tbl_burst[t]; b++) begin
                    p = {32'hd0d0_0000 | 32'(t), 32'(w), 32'(b),
                         lcg_next(32'(t * 4096 + w * 64 + b))};
                    push_word(4'd0, p, 1'b1);
                end
            end
            push_word(TAG_CHECKSUM, {32'hc5c5_c5c5, 96'(t)}, 1'b1);
            wait_level("wr_done high", wr_done, 1'b1);
            wait_level("header record", hdr_empty, 1'b0);
            hdr_rd_en = 1'b1;
            step();
            hdr_rd_en = 1'b0;
            acq_done = 1'b1;
            wait_level("wr_done low", wr_done, 1'b0);
            acq_done = 1'b0;
            acq_enabled = 1'b0;
            step();
            acq_enabled = 1'b1;
        end
        repeat (4) step();
        i_chk.end_test();
    endtask

    initial begin
        reset = 1'b1;
        acq_enabled = 1'b0;
        acq_done = 1'b0;
        adc_wr_en = 1'b0;
        adc_wr_dat = '0;
        app_wdf_rdy = 1'b0;
        app_rdy = 1'b0;
        fixed_start_addr = '0;
        fixed_start_en = 1'b0;
        hdr_rd_en = 1'b0;
        rnd_state = 32'd22391;
        duty = 100;
        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;
        acq_enabled = 1'b1;
        step();
        for (int t = 0; t < N_TESTS; t++) begin
            duty = tbl_duty[t];
            fixed_start_en = tbl_fixed[t];
            fixed_start_addr = tbl_faddr[t];
            run_fill(t);
        end
        i_chk.print_summary();
        if (i_chk.err_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- verification/ddr_wr_checker.sv
module ddr_wr_checker
    import ddr_wr_pkg::*;
(
    input logic                  clk,
    input logic                  reset,
    input logic                  app_wdf_wren,
    input logic                  app_wdf_end,
    input logic                  app_wdf_rdy,
    input logic [127:0]          app_wdf_data,
    input logic                  app_en,
    input logic                  app_rdy,
    input logic [APP_ADDR_W-1:0] app_addr,
    input logic                  hdr_rd_en,
    input hdr_record_t           hdr_rd_dat,
    input logic                  hdr_empty
);

    timeunit 1ns;
    timeprecision 100ps;

    int err_count = 0;
    int tests_passed = 0;
    int tests_failed = 0;

    // per-test state
    int                test_id;
    int                test_errs;
    int                word_idx;
    int                rec_count;
    int                beats_seen;
    bit                bad_fill;
    logic [ADDR_W-1:0] start_addr;
    hdr_record_t       exp_rec;

    // expected memory image in fill order, and beats awaiting their address
    logic [127:0]      exp_data_q [$];
    logic [ADDR_W-1:0] exp_addr_q [$];
    logic [127:0]      beat_q [$];

    task automatic flag(input string msg);
        $display("%s", msg);
        err_count++;
        test_errs++;
    endtask

    task automatic start_test(input int t, input logic [ADDR_W-1:0] start,
                              input logic [127:0] fill_hdr, input int nwfm,
                              input int bursts, input bit bad);
        int total;
        // header word, each waveform with its header, then checksum
        total = 1 + nwfm * (bursts + 1) + 1;
        test_id = t;
        test_errs = 0;
        word_idx = 0;
        rec_count = 0;
        beats_seen = 0;
        bad_fill = bad;
        start_addr = start;
        exp_rec.total_bursts = TOTAL_W'(total);
        exp_rec.fill_header = fill_hdr;
        exp_data_q.delete();
        exp_addr_q.delete();
        beat_q.delete();
    endtask

    // kth word of a fill goes to start plus k
    task automatic expect_word(input logic [127:0] p);
        exp_data_q.push_back(p);
        exp_addr_q.push_back(start_addr + ADDR_W'(word_idx));
        word_idx++;
    endtask

    always @(posedge clk) begin
        logic [127:0]      beat;
        logic [127:0]      exp_d;
        logic [ADDR_W-1:0] exp_a;
        if (!reset) begin
            if (app_en && app_rdy) begin
                if (beat_q.size() == 0) begin
                    flag("address accepted ahead of its data beat");
                end else if (exp_data_q.size() == 0) begin
                    flag("unexpected memory write");
                    beat = beat_q.pop_front();
                end else begin
                    beat = beat_q.pop_front();
                    exp_d = exp_data_q.pop_front();
                    exp_a = exp_addr_q.pop_front();
                    if (app_addr !== {exp_a, 3'b000}) begin
                        flag($sformatf("FAILED app_addr: expected %h got %h",
                                       {exp_a, 3'b000}, app_addr));
                    end
                    if (beat !== exp_d) begin
                        flag($sformatf("FAILED app_wdf_data: expected %h got %h", exp_d, beat));
                    end
                end
            end
            // one word per burst, so every offered beat closes its burst
            if (app_wdf_wren && app_wdf_end !== 1'b1) begin
                flag($sformatf("FAILED app_wdf_end: expected %h got %h", 1'b1, app_wdf_end));
            end
            if (app_wdf_wren && app_wdf_rdy) begin
                beat_q.push_back(app_wdf_data);
                beats_seen++;
            end
            if (hdr_rd_en && !hdr_empty) begin
                rec_count++;
                if (hdr_rd_dat !== exp_rec) begin
                    flag($sformatf("FAILED hdr_rd_dat: expected %h got %h", exp_rec, hdr_rd_dat));
                end
            end
        end
    end

    task automatic end_test();
        int exp_recs;
        exp_recs = bad_fill ? 0 : 1;
        if (exp_data_q.size() != 0) begin
            flag($sformatf("%0d expected memory words never written", exp_data_q.size()));
        end
        if (beat_q.size() != 0) begin
            flag($sformatf("%0d data beats left without an address", beat_q.size()));
        end
        if (rec_count != exp_recs) begin
            flag($sformatf("header records read %0d, expected %0d", rec_count, exp_recs));
        end
        if (!hdr_empty) begin
            flag("header FIFO holds an extra record");
        end
        if (test_errs == 0) begin
            tests_passed++;
            $display("test %0d passed, %0d beats", test_id, beats_seen);
        end else begin
            tests_failed++;
            $display("test %0d failed, %0d errors", test_id, test_errs);
        end
    endtask

    task automatic print_summary();
        $display("tests passed %0d, failed %0d, errors %0d",
                 tests_passed, tests_failed, err_count);
    endtask

endmodule

//--- verilog/ddr_wr_top.sv
module ddr_wr_top
    import ddr_wr_pkg::*;
#(
    parameter int DATA_FIFO_DEPTH = 64,
    parameter int HDR_FIFO_DEPTH  = 8
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  acq_enabled,
    input  logic                  acq_done,
    input  logic                  adc_wr_en,
    input  acq_word_t             adc_wr_dat,
    output logic                  adc_fifo_full,
    output logic                  app_wdf_wren,
    output logic                  app_wdf_end,
    output logic [127:0]          app_wdf_data,
    input  logic                  app_wdf_rdy,
    output logic                  app_en,
    output logic [APP_ADDR_W-1:0] app_addr,
    input  logic                  app_rdy,
    input  logic [ADDR_W-1:0]     fixed_start_addr,
    input  logic                  fixed_start_en,
    input  logic                  hdr_rd_en,
    output hdr_record_t           hdr_rd_dat,
    output logic                  hdr_empty,
    output logic                  sync_err,
    output logic                  wr_done
);

    acq_word_t   fifo_dat;
    logic        fifo_empty;
    logic        fifo_rd_en;
    hdr_record_t hdr_wr_dat;
    logic        hdr_wr_en;

    // tagged words from the ADC side
    fwft_fifo #(
        .payload_t (acq_word_t),
        .DEPTH     (DATA_FIFO_DEPTH)
    ) i_data_fifo (
        .clk    (clk),
        .reset  (reset),
        .wr_en  (adc_wr_en),
        .wr_dat (adc_wr_dat),
        .full   (adc_fifo_full),
        .rd_en  (fifo_rd_en),
        .rd_dat (fifo_dat),
        .empty  (fifo_empty)
    );

    ddr_wr_control i_control (
        .clk              (clk),
        .reset            (reset),
        .acq_enabled      (acq_enabled),
        .acq_done         (acq_done),
        .fifo_dat         (fifo_dat),
        .fifo_empty       (fifo_empty),
        .fifo_rd_en       (fifo_rd_en),
        .app_wdf_wren     (app_wdf_wren),
        .app_wdf_end      (app_wdf_end),
        .app_wdf_data     (app_wdf_data),
        .app_wdf_rdy      (app_wdf_rdy),
        .app_en           (app_en),
        .app_addr         (app_addr),
        .app_rdy          (app_rdy),
        .fixed_start_addr (fixed_start_addr),
        .fixed_start_en   (fixed_start_en),
        .hdr_wr_en        (hdr_wr_en),
        .hdr_wr_dat       (hdr_wr_dat),
        .sync_err         (sync_err),
        .wr_done          (wr_done)
    );

    // one record per fill for the readout stage
    // sized so it never fills
    fwft_fifo #(
        .payload_t (hdr_record_t),
        .DEPTH     (HDR_FIFO_DEPTH)
    ) i_hdr_fifo (
        .clk    (clk),
        .reset  (reset),
        .wr_en  (hdr_wr_en),
        .wr_dat (hdr_wr_dat),
        .full   (),
        .rd_en  (hdr_rd_en),
        .rd_dat (hdr_rd_dat),
        .empty  (hdr_empty)
    );

endmodule

//--- verilog/ddr_wr_control.sv
module ddr_wr_control
    import ddr_wr_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  acq_enabled,
    input  logic                  acq_done,
    input  acq_word_t             fifo_dat,
    input  logic                  fifo_empty,
    output logic                  fifo_rd_en,
    output logic                  app_wdf_wren,
    output logic                  app_wdf_end,
    output logic [127:0]          app_wdf_data,
    input  logic                  app_wdf_rdy,
    output logic                  app_en,
    output logic [APP_ADDR_W-1:0] app_addr,
    input  logic                  app_rdy,
    input  logic [ADDR_W-1:0]     fixed_start_addr,
    input  logic                  fixed_start_en,
    output logic                  hdr_wr_en,
    output hdr_record_t           hdr_wr_dat,
    output logic                  sync_err,
    output logic                  wr_done
);

    // one-hot state indices
    localparam int IDLE       = 0;
    localparam int TST_TAG    = 1;
    localparam int SYNC_ERR   = 2;
    localparam int INIT_FILL  = 3;
    localparam int INIT_WFM   = 4;
    localparam int INIT_CKSM  = 5;
    localparam int WRITE      = 6;
    localparam int WRITE_CKSM = 7;
    localparam int WRITE_HDR  = 8;
    localparam int DONE       = 9;
    localparam int N_STATES   = 10;

    // a waveform block is at most 2^14 bursts plus its header
    localparam int CNT_W = BURST_CNT_W + 1;

    logic [N_STATES-1:0] cs;
    logic [N_STATES-1:0] ns;
    logic                acq_done_meta;
    logic                acq_done_sync;
    logic                in_write;
    logic                data_accept;
    logic                addr_accept;
    logic [ADDR_W-1:0]   addr_gen;
    logic [CNT_W-1:0]    addr_cntr;
    logic [CNT_W-1:0]    burst_cntr;
    logic [CNT_W-1:0]    wfm_load;
    logic                addr_cntr_zero;
    logic                burst_cntr_zero;
    logic [CNT_W-1:0]    throttle;
    logic [TOTAL_W-1:0]  total_bursts;
    logic                blk_done;

    // acq_done comes from the ADC clock domain
    always_ff @(posedge clk) begin
        if (reset) begin
            acq_done_meta <= 1'b0;
            acq_done_sync <= 1'b0;
        end else begin
            acq_done_meta <= acq_done;
            acq_done_sync <= acq_done_meta;
        end
    end

    assign in_write    = cs[WRITE] || cs[WRITE_CKSM];
    assign data_accept = app_wdf_wren && app_wdf_rdy;
    assign addr_accept = app_en && app_rdy;

    // data burst count plus one for the waveform header itself
    assign wfm_load = {1'b0, fifo_dat.payload[BURST_CNT_LSB +: BURST_CNT_W]} + 1'b1;

    // word address loaded at the start of a fill and stepped per accepted address
    always_ff @(posedge clk) begin
        if (reset) begin
            addr_gen <= '0;
        end else if (cs[INIT_FILL]) begin
            addr_gen <= fixed_start_en ? fixed_start_addr
                                       : fifo_dat.payload[START_ADDR_LSB +: ADDR_W];
        end else if (addr_accept) begin
            addr_gen <= addr_gen + 1'b1;
        end
    end
    assign app_addr = {addr_gen, 3'b000};

    // addresses still to issue for the current block
    always_ff @(posedge clk) begin
        if (reset) begin
            addr_cntr <= '0;
        end else if (cs[INIT_FILL] || cs[INIT_CKSM]) begin
            addr_cntr <= CNT_W'(1);
        end else if (cs[INIT_WFM]) begin
            addr_cntr <= wfm_load;
        end else if (addr_accept && !addr_cntr_zero) begin
            addr_cntr <= addr_cntr - 1'b1;
        end
    end
    assign addr_cntr_zero = (addr_cntr == '0);

    // data beats still to send for the current block
    always_ff @(posedge clk) begin
        if (reset) begin
            burst_cntr <= '0;
        end else if (cs[INIT_FILL] || cs[INIT_CKSM]) begin
            burst_cntr <= CNT_W'(1);
        end else if (cs[INIT_WFM]) begin
            burst_cntr <= wfm_load;
        end else if (data_accept && !burst_cntr_zero) begin
            burst_cntr <= burst_cntr - 1'b1;
        end
    end
    assign burst_cntr_zero = (burst_cntr == '0);

    assign blk_done = addr_cntr_zero && burst_cntr_zero;

    // beats accepted but not yet addressed
    // returns to zero at the end of every block
    always_ff @(posedge clk) begin
        if (reset) begin
            throttle <= '0;
        end else if (data_accept && !addr_accept) begin
            throttle <= throttle + 1'b1;
        end else if (addr_accept && !data_accept) begin
            throttle <= throttle - 1'b1;
        end
    end

    // every word of the fill including headers and checksum
    always_ff @(posedge clk) begin
        if (reset) begin
            total_bursts <= '0;
        end else if (cs[INIT_FILL]) begin
            total_bursts <= '0;
        end else if (addr_accept) begin
            total_bursts <= total_bursts + 1'b1;
        end
    end

    // header record for the readout stage
    // fill header taken while it sits at the FIFO head
    always_ff @(posedge clk) begin
        if (cs[TST_TAG] && fifo_dat.tag == TAG_FILL_HDR) begin
            hdr_wr_dat.fill_header <= fifo_dat.payload;
        end
        // total is final once the checksum address is in
        if (cs[WRITE_CKSM] && blk_done) begin
            hdr_wr_dat.total_bursts <= total_bursts;
        end
    end

    // disabling acquisition parks the FSM, which also clears a sync error
    always_ff @(posedge clk) begin
        if (reset || !acq_enabled) begin
            cs       <= '0;
            cs[IDLE] <= 1'b1;
        end else begin
            cs <= ns;
        end
    end

    always_comb begin
        ns = '0;
        case (1'b1)
            cs[IDLE]: begin
                // a non-empty FWFT head is valid data
                if (fifo_empty) ns[IDLE] = 1'b1;
                else            ns[TST_TAG] = 1'b1;
            end
            cs[TST_TAG]: begin
                if (fifo_dat.tag == TAG_FILL_HDR)      ns[INIT_FILL] = 1'b1;
                else if (fifo_dat.tag == TAG_WFM_HDR)  ns[INIT_WFM] = 1'b1;
                else if (fifo_dat.tag == TAG_CHECKSUM) ns[INIT_CKSM] = 1'b1;
                else                                   ns[SYNC_ERR] = 1'b1;
            end
            // lost framing until acq_enabled drops
            cs[SYNC_ERR]:  ns[SYNC_ERR] = 1'b1;
            cs[INIT_FILL]: ns[WRITE] = 1'b1;
            cs[INIT_WFM]:  ns[WRITE] = 1'b1;
            cs[INIT_CKSM]: ns[WRITE_CKSM] = 1'b1;
            cs[WRITE]: begin
                // back to IDLE for the next waveform or the checksum
                if (blk_done) ns[IDLE] = 1'b1;
                else          ns[WRITE] = 1'b1;
            end
            cs[WRITE_CKSM]: begin
                if (blk_done) ns[WRITE_HDR] = 1'b1;
                else          ns[WRITE_CKSM] = 1'b1;
            end
            cs[WRITE_HDR]: ns[DONE] = 1'b1;
            cs[DONE]: begin
                if (acq_done_sync) ns[IDLE] = 1'b1;
                else               ns[DONE] = 1'b1;
            end
            default: ns[IDLE] = 1'b1;
        endcase
    end

    // one word per burst, so every beat is also the last
    assign app_wdf_wren = in_write && !fifo_empty && !burst_cntr_zero;
    assign app_wdf_end  = app_wdf_wren;
    assign app_wdf_data = fifo_dat.payload;

    // pop the head once the memory has taken it
    assign fifo_rd_en = data_accept;

    // address only after its data beat went in
    assign app_en = in_write && (throttle != '0) && !addr_cntr_zero;

    // status straight from the state flops
    assign hdr_wr_en = cs[WRITE_HDR];
    assign sync_err  = cs[SYNC_ERR];
    assign wr_done   = cs[DONE];

    a_state_onehot: assert property (@(posedge clk) disable iff (reset) $onehot(cs))
        else $error("ddr_wr_control: state vector not one-hot");

    // accepted beats and accepted addresses balance when a block ends
    a_throttle_balanced: assert property (@(posedge clk) disable iff (reset)
        (in_write && blk_done) |-> (throttle == '0))
        else $error("ddr_wr_control: throttle count not zero at block end");

endmodule

//--- verilog/fwft_fifo.sv
module fwft_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 16
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     wr_en,
    input  payload_t wr_dat,
    output logic     full,
    input  logic     rd_en,
    output payload_t rd_dat,
    output logic     empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_wr;
    logic             do_rd;

    // occupancy flags straight from the count
    assign full  = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);

    // pointers move only on legal requests
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    // head entry is always presented
    // valid whenever empty is low
    assign rd_dat = mem[rd_ptr];

    // storage written at the tail
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_dat;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // pointers wrap at DEPTH
            // DEPTH need not be a power of two
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // producer must watch full
    a_no_overflow: assert property (@(posedge clk) disable iff (reset) !(wr_en && full))
        else $error("fwft_fifo: write while full");

    // consumer must watch empty
    a_no_underflow: assert property (@(posedge clk) disable iff (reset) !(rd_en && empty))
        else $error("fwft_fifo: read while empty");

endmodule

//--- verilog/ddr_wr_pkg.sv
package ddr_wr_pkg;

    // tag codes carried in the upper nibble of every acquisition word
    localparam logic [3:0] TAG_FILL_HDR = 4'd1;
    localparam logic [3:0] TAG_WFM_HDR  = 4'd2;
    localparam logic [3:0] TAG_CHECKSUM = 4'd4;

    // word address into the acquisition memory, one word per burst
    localparam int ADDR_W = 23;

    // byte address to the DDR3 app port
    // the word address with three zero lsbs
    localparam int APP_ADDR_W = 26;

    // burst count field of a waveform header
    localparam int BURST_CNT_W = 14;

    // total bursts of one fill, appended to the header record
    localparam int TOTAL_W = 24;

    // start address field inside the fill header payload
    localparam int START_ADDR_LSB = 53;

    // burst count field inside the waveform header payload
    localparam int BURST_CNT_LSB = 0;

    // one word from the ADC side
    // tag sits in the top four bits
    typedef struct packed {
        logic [3:0]   tag;
        logic [127:0] payload;
    } acq_word_t;

    // one header FIFO entry for the readout stage
    // fill header without its tag
    // total burst count in the upper bits
    typedef struct packed {
        logic [TOTAL_W-1:0] total_bursts;
        logic [127:0]       fill_header;
    } hdr_record_t;

endpackage
